//--- build.f
logic/dpu_pkg.sv
logic/dpu_decode.sv
logic/dpu_execute.sv
logic/dpu_result.sv
logic/dpu_top.sv
testbench/tb_clock.sv
testbench/dpu_chk.sv
testbench/dpu_tb.sv

//--- logic/dpu_decode.sv
// Decode stage of the dot-product pipeline, unpacks and extends the operand lanes by opcode
`timescale 1ns/100ps
`default_nettype none

module dpu_decode (
    input  wire                                             clk,
    input  wire                                             reset,
    input  wire                                             advance,

    input  wire                                             in_valid,
    input  wire dpu_pkg::dpu_op_e                           op,
    input  wire [dpu_pkg::NUM_WORDS*dpu_pkg::XLEN-1:0]      a_row,
    input  wire [dpu_pkg::NUM_WORDS*dpu_pkg::XLEN-1:0]      b_col,
    input  wire [dpu_pkg::XLEN-1:0]                         c_val,

    output logic                                            dec_valid,
    output dpu_pkg::dpu_op_e                                dec_op,
    output logic [dpu_pkg::NUM_LANES-1:0][dpu_pkg::LANE_W-1:0] dec_a,
    output logic [dpu_pkg::NUM_LANES-1:0][dpu_pkg::LANE_W-1:0] dec_b,
    output logic [dpu_pkg::XLEN-1:0]                        dec_c
);

    logic [dpu_pkg::NUM_LANES-1:0][dpu_pkg::LANE_W-1:0] lane_a;
    logic [dpu_pkg::NUM_LANES-1:0][dpu_pkg::LANE_W-1:0] lane_b;

    // Word i sits at bits 32i+31:32i, so halves and bytes count up from bit 0
    always_comb begin
        for (int l = 0; l < dpu_pkg::NUM_LANES; l++) begin
            case (op)
                dpu_pkg::op_i16: begin
                    // Only the low four lanes carry 16-bit elements
                    if (l < dpu_pkg::NUM_LANES / 2) begin
                        lane_a[l] = {a_row[l*16+15], a_row[l*16 +: 16]};
                        lane_b[l] = {b_col[l*16+15], b_col[l*16 +: 16]};
                    end else begin
                        lane_a[l] = '0;
                        lane_b[l] = '0;
                    end
                end
                dpu_pkg::op_i8: begin
                    lane_a[l] = {{9{a_row[l*8+7]}}, a_row[l*8 +: 8]};
                    lane_b[l] = {{9{b_col[l*8+7]}}, b_col[l*8 +: 8]};
                end
                dpu_pkg::op_u8: begin
                    lane_a[l] = {9'd0, a_row[l*8 +: 8]};
                    lane_b[l] = {9'd0, b_col[l*8 +: 8]};
                end
                default: begin
                    // Illegal code contributes nothing
                    lane_a[l] = '0;
                    lane_b[l] = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (advance) begin
            dec_valid <= in_valid;
        end
    end

    // Payload follows the valid bit, a bubble just carries stale data
    always_ff @(posedge clk) begin
        if (advance) begin
            dec_op <= op;
            dec_a  <= lane_a;
            dec_b  <= lane_b;
            dec_c  <= c_val;
        end
    end

endmodule

`default_nettype wire

//--- logic/dpu_execute.sv
// Execute stage of the dot-product pipeline, lane multipliers feeding a three-level adder tree
`timescale 1ns/100ps
`default_nettype none

module dpu_execute (
    input  wire                                             clk,
    input  wire                                             reset,
    input  wire                                             advance,

    input  wire                                             dec_valid,
    input  wire dpu_pkg::dpu_op_e                           dec_op,
    input  wire [dpu_pkg::NUM_LANES-1:0][dpu_pkg::LANE_W-1:0] dec_a,
    input  wire [dpu_pkg::NUM_LANES-1:0][dpu_pkg::LANE_W-1:0] dec_b,
    input  wire [dpu_pkg::XLEN-1:0]                         dec_c,

    output logic                                            exe_valid,
    output logic                                            exe_bad,
    output logic [dpu_pkg::SUM_W-1:0]                       exe_sum,
    output logic [dpu_pkg::XLEN-1:0]                        exe_c
);

    logic signed [dpu_pkg::PROD_W-1:0] prod   [dpu_pkg::NUM_LANES];
    logic signed [dpu_pkg::PROD_W:0]   sum_l1 [dpu_pkg::NUM_LANES/2];
    logic signed [dpu_pkg::PROD_W+1:0] sum_l2 [dpu_pkg::NUM_LANES/4];
    logic signed [dpu_pkg::SUM_W-1:0]  sum_l3;
    logic                              is_bad;

    assign is_bad = (dec_op == dpu_pkg::op_bad);

    // Lanes are already extended, so every product is a plain signed multiply
    always_comb begin
        for (int l = 0; l < dpu_pkg::NUM_LANES; l++) begin
            prod[l] = $signed(dec_a[l]) * $signed(dec_b[l]);
        end
    end

    // Pairwise reduction, each level one bit wider than the one below
    always_comb begin
        for (int i = 0; i < dpu_pkg::NUM_LANES / 2; i++) begin
            sum_l1[i] = prod[2*i] + prod[2*i+1];
        end
        for (int i = 0; i < dpu_pkg::NUM_LANES / 4; i++) begin
            sum_l2[i] = sum_l1[2*i] + sum_l1[2*i+1];
        end
        sum_l3 = sum_l2[0] + sum_l2[1];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exe_valid <= 1'b0;
        end else if (advance) begin
            exe_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            exe_bad <= is_bad;
            // Illegal opcode passes the accumulator through untouched
            exe_sum <= is_bad ? '0 : sum_l3;
            exe_c   <= dec_c;
        end
    end

endmodule

`default_nettype wire

//--- logic/dpu_pkg.sv
// Shared widths, lane counts and opcode encoding for the integer dot-product unit
`default_nettype none

package dpu_pkg;

    // Register width and operand shape
    localparam int XLEN      = 32;
    localparam int NUM_WORDS = 2;

    // Eight lanes in the byte formats, four of them used for 16-bit lanes
    localparam int NUM_LANES = 8;

    // A lane carries one spare bit so signed and zero-extended values share a width
    localparam int LANE_W = 17;

    // Product of two extended lanes
    localparam int PROD_W = 2 * LANE_W;

    // Three adder tree levels grow the sum by one bit each
    localparam int SUM_W = PROD_W + 3;

    // Sum plus the sign-extended accumulator
    localparam int ACC_W = SUM_W + 1;

    // Operand formats, the last code is reserved
    typedef enum logic [1:0] {
        op_i16 = 2'd0,
        op_i8  = 2'd1,
        op_u8  = 2'd2,
        op_bad = 2'd3
    } dpu_op_e;

endpackage

`default_nettype wire

//--- logic/dpu_result.sv
// Result stage of the dot-product pipeline, accumulates, saturates and runs the output handshake
`timescale 1ns/100ps
`default_nettype none

module dpu_result (
    input  wire                             clk,
    input  wire                             reset,

    input  wire                             exe_valid,
    input  wire                             exe_bad,
    input  wire [dpu_pkg::SUM_W-1:0]        exe_sum,
    input  wire [dpu_pkg::XLEN-1:0]         exe_c,

    input  wire                             d_ready,
    output logic                            advance,
    output logic                            d_valid,
    output logic                            d_err,
    output logic [dpu_pkg::XLEN-1:0]        d_val
);

    logic signed [dpu_pkg::ACC_W-1:0] acc_sum;
    logic                             all_ones;
    logic                             all_zeros;
    logic [dpu_pkg::XLEN-1:0]         sat_val;

    // Whole pipeline moves when the output slot is free or being emptied
    assign advance = ~d_valid | d_ready;

    // Both operands sign-extend to the accumulator width
    assign acc_sum = $signed(exe_sum) + $signed(exe_c);

    // In range only when the bits above bit 31 all repeat the sign
    assign all_ones  = &acc_sum[dpu_pkg::ACC_W-1:dpu_pkg::XLEN-1];
    assign all_zeros = ~|acc_sum[dpu_pkg::ACC_W-1:dpu_pkg::XLEN-1];

    always_comb begin
        if (all_ones || all_zeros) begin
            sat_val = acc_sum[dpu_pkg::XLEN-1:0];
        end else if (acc_sum[dpu_pkg::ACC_W-1]) begin
            // Clamp negative overflow to the most negative word
            sat_val = {1'b1, {(dpu_pkg::XLEN-1){1'b0}}};
        end else begin
            sat_val = {1'b0, {(dpu_pkg::XLEN-1){1'b1}}};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            d_valid <= 1'b0;
            d_err   <= 1'b0;
        end else if (advance) begin
            d_valid <= exe_valid;
            // Error flag only rises with a real item
            d_err   <= exe_valid & exe_bad;
        end
    end

    // Held while the consumer stalls
    always_ff @(posedge clk) begin
        if (advance) begin
            d_val <= sat_val;
        end
    end

endmodule

`default_nettype wire

//--- logic/dpu_top.sv
// Top level of the integer dot-product unit, chains the decode, execute and result stages
`timescale 1ns/100ps
`default_nettype none

module dpu_top (
    input  wire                                             clk,
    input  wire                                             reset,

    // Operand side
    input  wire                                             in_valid,
    output logic                                            in_ready,
    input  wire dpu_pkg::dpu_op_e                           op,
    input  wire [dpu_pkg::NUM_WORDS*dpu_pkg::XLEN-1:0]      a_row,
    input  wire [dpu_pkg::NUM_WORDS*dpu_pkg::XLEN-1:0]      b_col,
    input  wire [dpu_pkg::XLEN-1:0]                         c_val,

    // Result side
    output logic                                            d_valid,
    input  wire                                             d_ready,
    output logic [dpu_pkg::XLEN-1:0]                        d_val,
    output logic                                            d_err
);

    wire                                                advance;

    wire                                                dec_valid;
    wire dpu_pkg::dpu_op_e                              dec_op;
    wire [dpu_pkg::NUM_LANES-1:0][dpu_pkg::LANE_W-1:0]  dec_a;
    wire [dpu_pkg::NUM_LANES-1:0][dpu_pkg::LANE_W-1:0]  dec_b;
    wire [dpu_pkg::XLEN-1:0]                            dec_c;

    wire                                                exe_valid;
    wire                                                exe_bad;
    wire [dpu_pkg::SUM_W-1:0]                           exe_sum;
    wire [dpu_pkg::XLEN-1:0]                            exe_c;

    // A new operand is taken whenever the pipeline steps
    assign in_ready = advance;

    dpu_decode decode_i (
        .clk       (clk),
        .reset     (reset),
        .advance   (advance),
        .in_valid  (in_valid),
        .op        (op),
        .a_row     (a_row),
        .b_col     (b_col),
        .c_val     (c_val),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .dec_a     (dec_a),
        .dec_b     (dec_b),
        .dec_c     (dec_c)
    );

    dpu_execute execute_i (
        .clk       (clk),
        .reset     (reset),
        .advance   (advance),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .dec_a     (dec_a),
        .dec_b     (dec_b),
        .dec_c     (dec_c),
        .exe_valid (exe_valid),
        .exe_bad   (exe_bad),
        .exe_sum   (exe_sum),
        .exe_c     (exe_c)
    );

    // Owns the stall decision for all three stages
    dpu_result result_i (
        .clk       (clk),
        .reset     (reset),
        .exe_valid (exe_valid),
        .exe_bad   (exe_bad),
        .exe_sum   (exe_sum),
        .exe_c     (exe_c),
        .d_ready   (d_ready),
        .advance   (advance),
        .d_valid   (d_valid),
        .d_err     (d_err),
        .d_val     (d_val)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Builds the dot-product testbench with Verilator, runs it and checks the result

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module dpu_tb -f build.f -Mdir obj_dir -o dpu_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

# A failed assertion must not end the run before the closing report
sim_output=$(./obj_dir/dpu_sim +verilator+error+limit+1000)
sim_status=$?
echo "$sim_output"
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Regression passed" <<< "$sim_output"; then
    exit 0
else
    exit 1
fi

//--- testbench/dpu_chk.sv
// Concurrent handshake and reset checks that are bound into the dot-product top level
`timescale 1ns/100ps
`default_nettype none

module dpu_chk (
    input wire                      clk,
    input wire                      reset,
    input wire                      in_ready,
    input wire                      d_valid,
    input wire                      d_ready,
    input wire                      d_err,
    input wire [dpu_pkg::XLEN-1:0]  d_val
);

    int fail_count = 0;

    // A stalled result keeps its value and its flag
    hold_check: assert property (@(posedge clk) disable iff (reset)
        d_valid && !d_ready |=> d_valid && $stable(d_val) && $stable(d_err))
    else begin
        $error("Stalled result changed before it was taken");
        fail_count++;
    end

    // Input side stops exactly when the output is blocked
    stall_check: assert property (@(posedge clk) disable iff (reset)
        in_ready == !(d_valid && !d_ready))
    else begin
        $error("in_ready does not follow the output stall");
        fail_count++;
    end

    reset_check: assert property (@(posedge clk)
        reset |=> !d_valid && !d_err)
    else begin
        $error("Output valid or error flag high after reset");
        fail_count++;
    end

endmodule

bind dpu_top dpu_chk chk_i (
    .clk      (clk),
    .reset    (reset),
    .in_ready (in_ready),
    .d_valid  (d_valid),
    .d_ready  (d_ready),
    .d_err    (d_err),
    .d_val    (d_val)
);

`default_nettype wire

//--- testbench/dpu_tb.sv
// Testbench for the dot-product unit that runs directed and random operations against a lane model
`timescale 1ns/100ps
`default_nettype none

module dpu_tb;

    logic                                       clk;
    logic                                       reset;
    logic                                       in_valid;
    logic                                       in_ready;
    dpu_pkg::dpu_op_e                           op;
    logic [dpu_pkg::NUM_WORDS*dpu_pkg::XLEN-1:0] a_row;
    logic [dpu_pkg::NUM_WORDS*dpu_pkg::XLEN-1:0] b_col;
    logic [dpu_pkg::XLEN-1:0]                   c_val;
    logic                                       d_valid;
    logic                                       d_ready;
    logic [dpu_pkg::XLEN-1:0]                   d_val;
    logic                                       d_err;

    logic [31:0] stim_state;
    logic [31:0] ready_state;
    logic        ready_random;
    logic        check_latency;
    logic [32:0] expect_q[$];
    int          accept_q[$];
    logic [32:0] mon_expect;
    int          mon_accept;
    int          cycle_count = 0;
    int          value_errors = 0;
    int          order_errors = 0;
    int          timeout_errors = 0;

    tb_clock clock_i (
        .clk   (clk),
        .reset (reset)
    );

    dpu_top dut_i (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .op       (op),
        .a_row    (a_row),
        .b_col    (b_col),
        .c_val    (c_val),
        .d_valid  (d_valid),
        .d_ready  (d_ready),
        .d_val    (d_val),
        .d_err    (d_err)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_random();
        stim_state = lcg_step(stim_state);
        return stim_state;
    endfunction

    // Expected {d_err, d_val} from the exact lane sum clamped to 32 bits
    function automatic logic [32:0] model_result(input dpu_pkg::dpu_op_e code,
            input logic [63:0] a, input logic [63:0] b, input logic [31:0] c);
        longint total;
        longint ea;
        longint eb;
        if (code == dpu_pkg::op_bad) begin
            return {1'b1, c};
        end
        total = longint'($signed(c));
        if (code == dpu_pkg::op_i16) begin
            for (int l = 0; l < 4; l++) begin
                ea = longint'($signed(a[l*16 +: 16]));
                eb = longint'($signed(b[l*16 +: 16]));
                total = total + ea * eb;
            end
        end else begin
            for (int l = 0; l < 8; l++) begin
                if (code == dpu_pkg::op_i8) begin
                    ea = longint'($signed(a[l*8 +: 8]));
                    eb = longint'($signed(b[l*8 +: 8]));
                end else begin
                    ea = longint'(a[l*8 +: 8]);
                    eb = longint'(b[l*8 +: 8]);
                end
                total = total + ea * eb;
            end
        end
        if (total > 64'sd2147483647) begin
            return {1'b0, 32'h7fff_ffff};
        end else if (total < -64'sd2147483648) begin
            return {1'b0, 32'h8000_0000};
        end
        return {1'b0, total[31:0]};
    endfunction

    // Holds the operation until it is taken and returns on a falling edge
    task automatic send_op(input dpu_pkg::dpu_op_e code, input logic [63:0] a,
            input logic [63:0] b, input logic [31:0] c);
        int  waited;
        logic accepted;
        waited = 0;
        accepted = 1'b0;
        in_valid = 1'b1;
        op = code;
        a_row = a;
        b_col = b;
        c_val = c;
        while (!accepted && waited < 64) begin
            @(posedge clk);
            accepted = in_ready;
            waited++;
            @(negedge clk);
        end
        if (!accepted) begin
            $display("Operation was not accepted within 64 cycles");
            timeout_errors++;
        end
    endtask

    task automatic send_random_op();
        logic [31:0] r;
        logic [63:0] a;
        logic [63:0] b;
        logic [31:0] c;
        r = next_random();
        a[63:32] = next_random();
        a[31:0] = next_random();
        b[63:32] = next_random();
        b[31:0] = next_random();
        c = next_random();
        send_op(dpu_pkg::dpu_op_e'(r[9:8]), a, b, c);
    endtask

    task automatic drain_pipeline();
        int waited;
        waited = 0;
        in_valid = 1'b0;
        while (expect_q.size() != 0 && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (expect_q.size() != 0) begin
            $display("Pipeline did not drain, %0d results still pending", expect_q.size());
            timeout_errors++;
        end
    endtask

    // Output consumer that stalls at random only while enabled
    initial begin
        d_ready = 1'b1;
        ready_state = 32'hdb19_1851;
        forever begin
            @(negedge clk);
            if (ready_random) begin
                ready_state = lcg_step(ready_state);
                d_ready = ready_state[17];
            end else begin
                d_ready = 1'b1;
            end
        end
    end

    // Scoreboard checks the output side before queueing the new operation
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (!reset) begin
            if (d_valid && d_ready) begin
                if (expect_q.size() == 0) begin
                    $display("Result appeared with no operation outstanding");
                    order_errors++;
                end else begin
                    mon_expect = expect_q.pop_front();
                    mon_accept = accept_q.pop_front();
                    assert (d_val == mon_expect[31:0]) else begin
                        $display("Fail d_val: got %h, expected %h", d_val, mon_expect[31:0]);
                        value_errors++;
                    end
                    assert (d_err == mon_expect[32]) else begin
                        $display("Fail d_err: got %h, expected %h", d_err, mon_expect[32]);
                        value_errors++;
                    end
                    if (check_latency) begin
                        assert (cycle_count - mon_accept == 3) else begin
                            $display("Result took %0d cycles instead of 3",
                                     cycle_count - mon_accept);
                            order_errors++;
                        end
                    end
                end
            end
            if (in_valid && in_ready) begin
                expect_q.push_back(model_result(op, a_row, b_col, c_val));
                accept_q.push_back(cycle_count);
            end
        end
    end

    initial begin
        int waited;
        int total;
        // An illegal operation offered during reset must not reach the output
        in_valid = 1'b1;
        op = dpu_pkg::op_bad;
        a_row = '0;
        b_col = '0;
        c_val = 32'h0bad_0bad;
        stim_state = 32'hdb19_1851;
        check_latency = 1'b1;
        ready_random <= 1'b0;
        waited = 0;
        repeat (4) @(negedge clk);
        in_valid = 1'b0;
        while (reset && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        if (reset) begin
            $display("Reset was never released");
            timeout_errors++;
        end

        // Back-to-back directed operations with the output always ready
        send_op(dpu_pkg::op_i16, 64'h0003_fffe_7fff_8000, 64'h0002_0005_7fff_8000, 32'h10);
        send_op(dpu_pkg::op_i8, {8{8'h80}}, {8{8'hff}}, 32'h0);
        send_op(dpu_pkg::op_u8, {8{8'h80}}, {8{8'hff}}, 32'h0);
        send_op(dpu_pkg::op_i8, {8{8'hff}}, {8{8'hff}}, 32'hffff_fff0);
        send_op(dpu_pkg::op_u8, {8{8'hff}}, {8{8'hff}}, 32'h1);
        send_op(dpu_pkg::op_i8, {8{8'h80}}, {8{8'h80}}, 32'h0);
        // Sums of four extreme 16-bit products run past the word both ways
        send_op(dpu_pkg::op_i16, {4{16'h8000}}, {4{16'h8000}}, 32'h0000_0001);
        send_op(dpu_pkg::op_i16, {4{16'h8000}}, {4{16'h7fff}}, 32'h8000_0000);
        send_op(dpu_pkg::op_bad, {8{8'h12}}, {8{8'h34}}, 32'hdead_beef);
        send_op(dpu_pkg::op_i16, {4{16'h0102}}, {4{16'hfffd}}, 32'h0000_0100);
        for (int n = 0; n < 8; n++) begin
            send_random_op();
        end
        drain_pipeline();

        // Random traffic with gaps and output stalls
        check_latency = 1'b0;
        ready_random <= 1'b1;
        for (int n = 0; n < 300; n++) begin
            send_random_op();
            if (next_random() < 32'h3000_0000) begin
                in_valid = 1'b0;
                @(negedge clk);
            end
        end
        ready_random <= 1'b0;
        drain_pipeline();

        total = value_errors + order_errors + timeout_errors + dut_i.chk_i.fail_count;
        $display("Errors: %0d value, %0d ordering, %0d timeout, %0d assertion",
                 value_errors, order_errors, timeout_errors, dut_i.chk_i.fail_count);
        if (total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
// Clock and reset source for the dot-product testbench, 40 ns period with an 8-cycle reset
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire
